//--- Makefile
# Verilator build and run for the compute unit control shell

VERILATOR ?= verilator
TOP       ?= cu_control_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) cu_settings.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- cu_completion_tracker.sv
/*
 * Completion tracking. Registers the engine counts, sums processed and
 * filtered vertices, compares the totals with the work descriptor and
 * raises cu_done with the return values.
 */

`timescale 1ns/1ps

module cu_completion_tracker (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  run,
	input  cu_pkg::vertex_count_t vertices_done,
	input  cu_pkg::vertex_count_t vertices_filtered,
	input  cu_pkg::edge_count_t   edges_done,
	input  cu_pkg::vertex_count_t wed_num_vertices,
	input  cu_pkg::edge_count_t   wed_num_edges,
	output logic                  cu_done,
	output cu_pkg::vertex_count_t cu_return_vertices,
	output cu_pkg::edge_count_t   cu_return_edges
);

	import cu_pkg::*;

	// first stage holds the raw counts
	vertex_count_t vertices_done_q;
	vertex_count_t vertices_filtered_q;
	edge_count_t   edges_done_q;

	// second stage holds the totals
	vertex_count_t vertices_total;
	edge_count_t   edges_total;

	// third stage holds the compare result and return values
	logic          done_match;
	vertex_count_t return_vertices_q;
	edge_count_t   return_edges_q;

////////////////////////////////////////
// count pipeline
////////////////////////////////////////

	// every stage holds while the unit is not running
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertices_done_q     <= '0;
			vertices_filtered_q <= '0;
			edges_done_q        <= '0;
			vertices_total      <= '0;
			edges_total         <= '0;
		end else if (run) begin
			vertices_done_q     <= vertices_done;
			vertices_filtered_q <= vertices_filtered;
			edges_done_q        <= edges_done;
			vertices_total      <= vertices_done_q + vertices_filtered_q;
			edges_total         <= edges_done_q;
		end
	end

////////////////////////////////////////
// done compare and outputs
////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			done_match         <= 1'b0;
			return_vertices_q  <= '0;
			return_edges_q     <= '0;
			cu_done            <= 1'b0;
			cu_return_vertices <= '0;
			cu_return_edges    <= '0;
		end else if (run) begin
			done_match <= (vertices_total == wed_num_vertices) &&
				(edges_total == wed_num_edges);
			return_vertices_q  <= vertices_total;
			return_edges_q     <= edges_total;
			// done and its return values leave together
			cu_done            <= done_match;
			cu_return_vertices <= return_vertices_q;
			cu_return_edges    <= return_edges_q;
		end
	end

endmodule

//--- cu_control.sv
/*
 * Control shell of the graph compute unit. Latches the enable, the config
 * word and the work descriptor, then runs response steering, read command
 * arbitration and completion tracking.
 */

`timescale 1ns/1ps

module cu_control (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled_in,
	input  cu_pkg::config_word_t  config_word,
	input  logic                  wed_valid,
	input  cu_pkg::vertex_count_t wed_num_vertices,
	input  cu_pkg::edge_count_t   wed_num_edges,
	input  logic                  resp_valid,
	input  cu_pkg::cu_id_t        resp_cu_id,
	input  cu_pkg::resp_tag_t     resp_tag,
	input  logic                  vj_cmd_valid,
	input  cu_pkg::read_addr_t    vj_cmd_addr,
	output logic                  vj_cmd_ready,
	input  logic                  alg_cmd_valid,
	input  cu_pkg::read_addr_t    alg_cmd_addr,
	output logic                  alg_cmd_ready,
	input  cu_pkg::vertex_count_t vertices_done,
	input  cu_pkg::vertex_count_t vertices_filtered,
	input  cu_pkg::edge_count_t   edges_done,
	input  logic                  read_cmd_ready,
	output logic                  read_cmd_valid,
	output cu_pkg::read_addr_t    read_cmd_addr,
	output cu_pkg::cu_id_t        read_cmd_cu_id,
	output logic                  vj_resp_valid,
	output cu_pkg::resp_tag_t     vj_resp_tag,
	output logic                  alg_resp_valid,
	output cu_pkg::resp_tag_t     alg_resp_tag,
	output logic                  cu_done,
	output cu_pkg::vertex_count_t cu_return_vertices,
	output cu_pkg::edge_count_t   cu_return_edges,
	output cu_pkg::config_word_t  cu_status
);

	import cu_pkg::*;

	logic          enabled;
	config_word_t  config_latched;
	logic          wed_valid_latched;
	vertex_count_t wed_vertices_latched;
	edge_count_t   wed_edges_latched;
	logic          cu_ready;
	logic          run;

////////////////////////////////////////
// enable, config and descriptor
////////////////////////////////////////

	// a zero config word means no update, the last nonzero one stays
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled           <= 1'b0;
			config_latched    <= '0;
			wed_valid_latched <= 1'b0;
			cu_status         <= '0;
			run               <= 1'b0;
		end else begin
			enabled <= enabled_in;
			run     <= cu_ready;
			if (enabled) begin
				if (|config_word)
					config_latched <= config_word;
				if (wed_valid)
					wed_valid_latched <= 1'b1;
				cu_status <= config_latched;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enabled && wed_valid) begin
			wed_vertices_latched <= wed_num_vertices;
			wed_edges_latched    <= wed_num_edges;
		end
	end

	assign cu_ready = (|config_latched) && wed_valid_latched;

////////////////////////////////////////
// sub-blocks
////////////////////////////////////////

	cu_response_router u_response_router (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.resp_valid(resp_valid), .resp_cu_id(resp_cu_id), .resp_tag(resp_tag),
		.vj_resp_valid(vj_resp_valid), .vj_resp_tag(vj_resp_tag),
		.alg_resp_valid(alg_resp_valid), .alg_resp_tag(alg_resp_tag)
	);

	cu_read_arbiter u_read_arbiter (
		.clock(clock), .rstn(rstn), .run(run),
		.vj_cmd_valid(vj_cmd_valid), .vj_cmd_addr(vj_cmd_addr),
		.alg_cmd_valid(alg_cmd_valid), .alg_cmd_addr(alg_cmd_addr),
		.read_cmd_ready(read_cmd_ready),
		.vj_cmd_ready(vj_cmd_ready), .alg_cmd_ready(alg_cmd_ready),
		.read_cmd_valid(read_cmd_valid), .read_cmd_addr(read_cmd_addr),
		.read_cmd_cu_id(read_cmd_cu_id)
	);

	cu_completion_tracker u_completion_tracker (
		.clock(clock), .rstn(rstn), .run(run),
		.vertices_done(vertices_done), .vertices_filtered(vertices_filtered),
		.edges_done(edges_done),
		.wed_num_vertices(wed_vertices_latched), .wed_num_edges(wed_edges_latched),
		.cu_done(cu_done), .cu_return_vertices(cu_return_vertices),
		.cu_return_edges(cu_return_edges)
	);

endmodule

//--- cu_control_checker.sv
/*
 * Watches the DUT ports, keeps reference models of response steering and
 * read command ordering, and prints one line per test plus the counts.
 */

`timescale 1ns/1ps

module cu_control_checker (
	input logic                  clock,
	input logic                  rstn,
	input logic                  enabled_in,
	input logic                  resp_valid,
	input cu_pkg::cu_id_t        resp_cu_id,
	input cu_pkg::resp_tag_t     resp_tag,
	input logic                  vj_cmd_valid,
	input logic                  vj_cmd_ready,
	input cu_pkg::read_addr_t    vj_cmd_addr,
	input logic                  alg_cmd_valid,
	input logic                  alg_cmd_ready,
	input cu_pkg::read_addr_t    alg_cmd_addr,
	input logic                  read_cmd_ready,
	input logic                  read_cmd_valid,
	input cu_pkg::read_addr_t    read_cmd_addr,
	input cu_pkg::cu_id_t        read_cmd_cu_id,
	input logic                  vj_resp_valid,
	input cu_pkg::resp_tag_t     vj_resp_tag,
	input logic                  alg_resp_valid,
	input cu_pkg::resp_tag_t     alg_resp_tag,
	input logic                  cu_done,
	input cu_pkg::vertex_count_t cu_return_vertices,
	input cu_pkg::edge_count_t   cu_return_edges,
	input cu_pkg::config_word_t  cu_status
);

	import cu_pkg::*;

	int        error_count = 0;
	int        test_count = 0;
	int        failed_tests = 0;
	int        test_errors = 0;
	string     test_name;

	// response reference pipeline
	logic      en_q;
	logic      s1_valid;
	cu_id_t    s1_id;
	resp_tag_t s1_tag;
	logic      exp_vj;
	logic      exp_alg;
	resp_tag_t exp_tag;

	// read command reference
	read_addr_t exp_addr_q[$];
	cu_id_t     exp_id_q[$];
	logic       have_last = 1'b0;
	cu_id_t     last_winner;
	logic       stalled = 1'b0;
	read_addr_t stall_addr;
	cu_id_t     stall_id;

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t ns: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	task automatic report_failure(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

////////////////////////////////////////
// response steering
////////////////////////////////////////

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			en_q     <= 1'b0;
			s1_valid <= 1'b0;
			exp_vj   <= 1'b0;
			exp_alg  <= 1'b0;
		end else begin
			en_q     <= enabled_in;
			s1_valid <= en_q && resp_valid;
			s1_id    <= resp_cu_id;
			s1_tag   <= resp_tag;
			exp_vj   <= en_q && s1_valid && (s1_id == CU_ID_VERTEX_JOB);
			exp_alg  <= en_q && s1_valid && (s1_id != CU_ID_VERTEX_JOB);
			exp_tag  <= s1_tag;
		end
	end

	always @(negedge clock) begin
		if (rstn) begin
			if (vj_resp_valid !== exp_vj || alg_resp_valid !== exp_alg)
				report_mismatch($sformatf("resp valids vj=%b alg=%b, expected %b %b",
					vj_resp_valid, alg_resp_valid, exp_vj, exp_alg));
			else if (exp_vj && vj_resp_tag !== exp_tag)
				report_mismatch($sformatf("vj tag %h, expected %h", vj_resp_tag, exp_tag));
			else if (exp_alg && alg_resp_tag !== exp_tag)
				report_mismatch($sformatf("alg tag %h, expected %h", alg_resp_tag, exp_tag));
		end
	end

////////////////////////////////////////
// read command ordering and hold
////////////////////////////////////////

	always @(posedge clock) begin
		if (rstn) begin
			if (stalled && (!read_cmd_valid || read_cmd_addr !== stall_addr ||
				read_cmd_cu_id !== stall_id))
				report_mismatch("read command changed under back-pressure");
			if (read_cmd_valid && read_cmd_ready) begin
				if (exp_addr_q.size() == 0) begin
					report_failure("read command delivered with no matching grant");
				end else begin
					if (read_cmd_addr !== exp_addr_q[0] || read_cmd_cu_id !== exp_id_q[0])
						report_mismatch($sformatf("read cmd %h id %0d, expected %h id %0d",
							read_cmd_addr, read_cmd_cu_id, exp_addr_q[0], exp_id_q[0]));
					void'(exp_addr_q.pop_front());
					void'(exp_id_q.pop_front());
				end
			end
			if (read_cmd_valid && !read_cmd_ready && (vj_cmd_ready || alg_cmd_ready))
				report_failure("a requester was granted while the output was stalled");
			if (vj_cmd_ready && alg_cmd_ready)
				report_failure("both requesters granted in one cycle");
			if (vj_cmd_valid && vj_cmd_ready) begin
				if (alg_cmd_valid && have_last && last_winner == CU_ID_VERTEX_JOB)
					report_mismatch("vertex job side won two ties in a row");
				exp_addr_q.push_back(vj_cmd_addr);
				exp_id_q.push_back(CU_ID_VERTEX_JOB);
				last_winner = CU_ID_VERTEX_JOB;
				have_last = 1'b1;
			end else if (alg_cmd_valid && alg_cmd_ready) begin
				if (vj_cmd_valid && have_last && last_winner == CU_ID_ALGORITHM)
					report_mismatch("algorithm side won two ties in a row");
				exp_addr_q.push_back(alg_cmd_addr);
				exp_id_q.push_back(CU_ID_ALGORITHM);
				last_winner = CU_ID_ALGORITHM;
				have_last = 1'b1;
			end
			stalled    = read_cmd_valid && !read_cmd_ready;
			stall_addr = read_cmd_addr;
			stall_id   = read_cmd_cu_id;
		end
	end

////////////////////////////////////////
// per-test checks called by the testbench
////////////////////////////////////////

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
		test_count++;
	endtask

	task automatic end_test();
		if (test_errors != 0)
			failed_tests++;
		$display("test %0d %s: %s (%0d errors)", test_count, test_name,
			(test_errors == 0) ? "ok" : "failed", test_errors);
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			if (read_cmd_valid || vj_cmd_ready || alg_cmd_ready || cu_done || |cu_status)
				report_mismatch("outputs active before the unit was configured");
		end
	endtask

	task automatic expect_status(input config_word_t expected);
		if (cu_status !== expected)
			report_mismatch($sformatf("cu_status %h, expected %h", cu_status, expected));
	endtask

	task automatic expect_done_low(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			if (cu_done)
				report_mismatch("cu_done high before the totals matched");
		end
	endtask

	// cu_done must rise within limit cycles
	task automatic wait_done(input vertex_count_t exp_v, input edge_count_t exp_e,
		input int limit);
		int waited;
		waited = 0;
		while (!cu_done && waited < limit) begin
			@(negedge clock);
			waited++;
		end
		if (!cu_done)
			report_failure($sformatf("cu_done did not rise within %0d cycles", limit));
		else if (cu_return_vertices !== exp_v || cu_return_edges !== exp_e)
			report_mismatch($sformatf("return %0d/%0d, expected %0d/%0d",
				cu_return_vertices, cu_return_edges, exp_v, exp_e));
	endtask

	task automatic expect_drained(input int limit);
		int waited;
		waited = 0;
		while ((read_cmd_valid || exp_addr_q.size() != 0) && waited < limit) begin
			@(negedge clock);
			waited++;
		end
		if (exp_addr_q.size() != 0)
			report_failure($sformatf("%0d granted commands never arrived", exp_addr_q.size()));
	endtask

	task automatic print_summary();
		$display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
	endtask

endmodule

//--- cu_control_props.sv
/*
 * Concurrent assertions for the control shell, bound onto cu_control.
 * Covers the read command handshake, response exclusivity and done values.
 */

`timescale 1ns/1ps

module cu_control_props (
	input logic                  clock,
	input logic                  rstn,
	input logic                  read_cmd_valid,
	input logic                  read_cmd_ready,
	input cu_pkg::read_addr_t    read_cmd_addr,
	input cu_pkg::cu_id_t        read_cmd_cu_id,
	input logic                  vj_resp_valid,
	input logic                  alg_resp_valid,
	input logic                  cu_done,
	input cu_pkg::vertex_count_t cu_return_vertices,
	input cu_pkg::edge_count_t   cu_return_edges,
	input cu_pkg::vertex_count_t wed_vertices,
	input cu_pkg::edge_count_t   wed_edges
);

	// a stalled command keeps its payload until the memory side takes it
	cmd_hold: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid && !read_cmd_ready |=>
			read_cmd_valid && $stable(read_cmd_addr) && $stable(read_cmd_cu_id))
		else $error("read command changed while stalled");

	resp_onehot: assert property (@(posedge clock) disable iff (!rstn)
		!(vj_resp_valid && alg_resp_valid))
		else $error("both response valids high");

	done_values: assert property (@(posedge clock) disable iff (!rstn)
		cu_done |-> (cu_return_vertices == wed_vertices) && (cu_return_edges == wed_edges))
		else $error("done raised with wrong return values");

endmodule

bind cu_control cu_control_props u_props (
	.clock(clock), .rstn(rstn),
	.read_cmd_valid(read_cmd_valid), .read_cmd_ready(read_cmd_ready),
	.read_cmd_addr(read_cmd_addr), .read_cmd_cu_id(read_cmd_cu_id),
	.vj_resp_valid(vj_resp_valid), .alg_resp_valid(alg_resp_valid),
	.cu_done(cu_done), .cu_return_vertices(cu_return_vertices),
	.cu_return_edges(cu_return_edges),
	.wed_vertices(wed_vertices_latched), .wed_edges(wed_edges_latched)
);

//--- cu_control_tb.sv
/*
 * Testbench for the control shell. Applies a table of test rows, models the
 * two read requesters and the memory side, and gives the final verdict.
 */

`timescale 1ns/1ps

module cu_control_tb;

	import cu_pkg::*;

	localparam int K_IDLE   = 0;
	localparam int K_CONFIG = 1;
	localparam int K_RESP   = 2;
	localparam int K_ARB    = 3;
	localparam int K_DONE   = 4;
	localparam int NUM_ROWS = 10;

	typedef struct {
		int           kind;
		logic [3:0]   id;
		int           n;
		logic [31:0]  a;
		logic [31:0]  b;
		logic [31:0]  c;
		config_word_t cfg;
		config_word_t expv;
		int           cycles;
	} row_t;

	row_t          rows[NUM_ROWS];
	int            seed = 75371;
	int            cycle_count = 0;
	int            cycle_limit = 0;
	vertex_count_t wed_v;
	edge_count_t   wed_e;

	logic          clock = 1'b0;
	logic          rstn;
	logic          enabled_in;
	logic          wed_valid;
	logic          resp_valid;
	logic          read_cmd_ready;
	config_word_t  config_word;
	vertex_count_t wed_num_vertices;
	vertex_count_t vertices_done;
	vertex_count_t vertices_filtered;
	edge_count_t   wed_num_edges;
	edge_count_t   edges_done;
	cu_id_t        resp_cu_id;
	resp_tag_t     resp_tag;
	logic          vj_cmd_valid;
	logic          vj_cmd_ready;
	logic          alg_cmd_valid;
	logic          alg_cmd_ready;
	read_addr_t    vj_cmd_addr;
	read_addr_t    alg_cmd_addr;
	read_addr_t    read_cmd_addr;
	logic          read_cmd_valid;
	logic          vj_resp_valid;
	logic          alg_resp_valid;
	logic          cu_done;
	cu_id_t        read_cmd_cu_id;
	resp_tag_t     vj_resp_tag;
	resp_tag_t     alg_resp_tag;
	vertex_count_t cu_return_vertices;
	edge_count_t   cu_return_edges;
	config_word_t  cu_status;
	logic          vj_fire = 1'b0;
	logic          alg_fire = 1'b0;

	always #20 clock = ~clock;

	cu_control UUT (.*);

	cu_control_checker u_checker (.*);

	// requester models read back the transfers taken on the rising edge
	always @(posedge clock) begin
		vj_fire  <= vj_cmd_valid && vj_cmd_ready;
		alg_fire <= alg_cmd_valid && alg_cmd_ready;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic read_addr_t random_addr();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[47:0];
	endfunction

	function automatic resp_tag_t random_tag();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// both requesters keep asking until n commands are accepted
	task automatic run_commands(input int n, input int stall);
		int accepted;
		int cyc;
		accepted = 0;
		cyc = 0;
		vj_cmd_addr = random_addr();
		alg_cmd_addr = random_addr();
		vj_cmd_valid = 1'b1;
		alg_cmd_valid = 1'b1;
		read_cmd_ready = (stall == 0);
		while (accepted < n) begin
			@(negedge clock);
			cyc++;
			if (cyc >= stall)
				read_cmd_ready = 1'b1;
			if (vj_fire) begin
				accepted++;
				vj_cmd_addr = random_addr();
			end
			if (alg_fire) begin
				accepted++;
				alg_cmd_addr = random_addr();
			end
			if (accepted >= n) begin
				vj_cmd_valid = 1'b0;
				alg_cmd_valid = 1'b0;
			end
		end
		u_checker.expect_drained(8);
	endtask

	task automatic apply_row(input row_t r);
		case (r.kind)
			K_IDLE: begin
				u_checker.begin_test("idle after reset");
				resp_valid = 1'b1;
				vj_cmd_valid = 1'b1;
				alg_cmd_valid = 1'b1;
				u_checker.check_idle(r.cycles);
				resp_valid = 1'b0;
				vj_cmd_valid = 1'b0;
				alg_cmd_valid = 1'b0;
			end
			K_CONFIG: begin
				u_checker.begin_test("config and status");
				enabled_in = 1'b1;
				config_word = r.cfg;
				wed_valid = 1'b1;
				wed_num_vertices = r.a;
				wed_num_edges = r.c;
				wed_v = r.a;
				wed_e = r.c;
				repeat (3) @(negedge clock);
				config_word = '0;
				wed_valid = 1'b0;
				repeat (r.cycles) @(negedge clock);
				u_checker.expect_status(r.expv);
			end
			K_RESP: begin
				u_checker.begin_test("response steering");
				repeat (r.n) begin
					resp_valid = 1'b1;
					resp_cu_id = cu_id_t'(r.id);
					resp_tag = random_tag();
					@(negedge clock);
				end
				resp_valid = 1'b0;
				repeat (4) @(negedge clock);
			end
			K_ARB: begin
				u_checker.begin_test((r.b == 0) ? "round robin" : "back-pressure");
				run_commands(r.n, r.b);
			end
			default: begin
				u_checker.begin_test("completion");
				vertices_done = r.a;
				vertices_filtered = r.b;
				edges_done = r.c;
				// done is expected only when both totals reach the descriptor
				if (r.a + r.b == wed_v && r.c == wed_e)
					u_checker.wait_done(r.a + r.b, r.c, 4);
				else
					u_checker.expect_done_low(r.cycles);
			end
		endcase
		u_checker.end_test();
	endtask

	initial begin
		rows[0] = '{K_IDLE, 4'd0, 0, 0, 0, 0, '0, '0, 8};
		rows[1] = '{K_CONFIG, 4'd0, 0, 100, 0, 300, 64'h0123_4567_89ab_cdef,
			64'h0123_4567_89ab_cdef, 8};
		rows[2] = '{K_CONFIG, 4'd0, 0, 100, 0, 300, '0, 64'h0123_4567_89ab_cdef, 8};
		rows[3] = '{K_RESP, 4'd1, 6, 0, 0, 0, '0, '0, 12};
		rows[4] = '{K_RESP, 4'd2, 6, 0, 0, 0, '0, '0, 12};
		rows[5] = '{K_RESP, 4'd9, 4, 0, 0, 0, '0, '0, 10};
		rows[6] = '{K_ARB, 4'd0, 10, 0, 0, 0, '0, '0, 30};
		rows[7] = '{K_ARB, 4'd0, 6, 0, 8, 0, '0, '0, 30};
		rows[8] = '{K_DONE, 4'd0, 0, 60, 30, 300, '0, '0, 10};
		rows[9] = '{K_DONE, 4'd0, 0, 60, 40, 300, '0, '0, 10};
		for (int i = 0; i < NUM_ROWS; i++)
			cycle_limit += rows[i].cycles;
		cycle_limit += 100;

		rstn = 1'b0;
		enabled_in = 1'b0;
		config_word = '0;
		wed_valid = 1'b0;
		wed_num_vertices = '0;
		wed_num_edges = '0;
		resp_valid = 1'b0;
		resp_cu_id = CU_ID_VERTEX_JOB;
		resp_tag = '0;
		vj_cmd_valid = 1'b0;
		vj_cmd_addr = '0;
		alg_cmd_valid = 1'b0;
		alg_cmd_addr = '0;
		vertices_done = '0;
		vertices_filtered = '0;
		edges_done = '0;
		read_cmd_ready = 1'b1;
		repeat (4) @(negedge clock);
		rstn = 1'b1;

		for (int i = 0; i < NUM_ROWS; i++)
			apply_row(rows[i]);

		u_checker.print_summary();
		if (u_checker.error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- cu_pkg.sv
/*
 * Shared types for the compute unit control shell.
 * Modules import it inside their body and use scoped names in port lists.
 */

package cu_pkg;

`include "cu_settings.svh"

	// owner of a read command or a read response
	typedef enum logic [`CU_ID_BITS-1:0] {
		CU_ID_VERTEX_JOB = `CU_VERTEX_JOB_ID,
		CU_ID_ALGORITHM  = `CU_ALGORITHM_ID
	} cu_id_t;

	// side that won the last arbitration round
	typedef enum logic {
		ARB_OWNER_VERTEX_JOB = 1'b0,
		ARB_OWNER_ALGORITHM  = 1'b1
	} arb_owner_t;

	////////////////////////////////////////
	// counters
	////////////////////////////////////////

	typedef logic [`CU_VERTEX_BITS-1:0] vertex_count_t;
	typedef logic [`CU_EDGE_BITS-1:0] edge_count_t;

	////////////////////////////////////////
	// command, response and config payloads
	////////////////////////////////////////

	typedef logic [`CU_ADDR_BITS-1:0] read_addr_t;
	typedef logic [`CU_TAG_BITS-1:0] resp_tag_t;

	// config word on the way in, status word on the way out
	typedef logic [`CU_CONFIG_BITS-1:0] config_word_t;

endpackage

//--- cu_read_arbiter.sv
/*
 * Round-robin merge of the vertex job and algorithm read commands into one
 * registered output. A new command is taken only when the output slot is
 * free or drains in the same cycle.
 */

`timescale 1ns/1ps

`include "cu_settings.svh"

module cu_read_arbiter (
	input  logic               clock,
	input  logic               rstn,
	input  logic               run,
	input  logic               vj_cmd_valid,
	input  cu_pkg::read_addr_t vj_cmd_addr,
	input  logic               alg_cmd_valid,
	input  cu_pkg::read_addr_t alg_cmd_addr,
	input  logic               read_cmd_ready,
	output logic               vj_cmd_ready,
	output logic               alg_cmd_ready,
	output logic               read_cmd_valid,
	output cu_pkg::read_addr_t read_cmd_addr,
	output cu_pkg::cu_id_t     read_cmd_cu_id
);

	import cu_pkg::*;

	// request and grant bit positions
	localparam int REQ_VJ  = 0;
	localparam int REQ_ALG = 1;

	logic [`CU_NUM_REQUESTERS-1:0] request;
	logic [`CU_NUM_REQUESTERS-1:0] grant;
	arb_owner_t                    last_owner;
	logic                          slot_free;
	logic                          drain;

	assign request[REQ_VJ]  = vj_cmd_valid;
	assign request[REQ_ALG] = alg_cmd_valid;

	// slot is written when empty or when the memory side takes it now
	assign drain     = read_cmd_valid && read_cmd_ready;
	assign slot_free = run && (!read_cmd_valid || read_cmd_ready);

////////////////////////////////////////
// grant selection
////////////////////////////////////////

	// on a tie the side that lost last time goes first
	always_comb begin
		grant = '0;
		if (slot_free) begin
			if (request[REQ_VJ] &&
				(!request[REQ_ALG] || last_owner == ARB_OWNER_ALGORITHM))
				grant[REQ_VJ] = 1'b1;
			else if (request[REQ_ALG])
				grant[REQ_ALG] = 1'b1;
		end
	end

	assign vj_cmd_ready  = grant[REQ_VJ];
	assign alg_cmd_ready = grant[REQ_ALG];

////////////////////////////////////////
// output slot
////////////////////////////////////////

	// starts as if algorithm won last, so vertex job gets the first tie
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_cmd_valid <= 1'b0;
			last_owner     <= ARB_OWNER_ALGORITHM;
		end else begin
			if (|grant) begin
				read_cmd_valid <= 1'b1;
				if (grant[REQ_VJ])
					last_owner <= ARB_OWNER_VERTEX_JOB;
				else
					last_owner <= ARB_OWNER_ALGORITHM;
			end else if (drain) begin
				read_cmd_valid <= 1'b0;
			end
		end
	end

	// payload holds while the slot waits on read_cmd_ready
	always_ff @(posedge clock) begin
		if (grant[REQ_VJ]) begin
			read_cmd_addr  <= vj_cmd_addr;
			read_cmd_cu_id <= CU_ID_VERTEX_JOB;
		end else if (grant[REQ_ALG]) begin
			read_cmd_addr  <= alg_cmd_addr;
			read_cmd_cu_id <= CU_ID_ALGORITHM;
		end
	end

endmodule

//--- cu_response_router.sv
/*
 * Read response steering. Each response is latched, then sent to the vertex
 * job side or the algorithm side by its unit id, two cycles after it arrives.
 */

`timescale 1ns/1ps

module cu_response_router (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled,
	input  logic              resp_valid,
	input  cu_pkg::cu_id_t    resp_cu_id,
	input  cu_pkg::resp_tag_t resp_tag,
	output logic              vj_resp_valid,
	output cu_pkg::resp_tag_t vj_resp_tag,
	output logic              alg_resp_valid,
	output cu_pkg::resp_tag_t alg_resp_tag
);

	import cu_pkg::*;

	// input latch stage
	logic      resp_valid_q;
	cu_id_t    resp_cu_id_q;
	resp_tag_t resp_tag_q;

////////////////////////////////////////
// input latch
////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_valid_q <= 1'b0;
		end else begin
			resp_valid_q <= enabled && resp_valid;
		end
	end

	always_ff @(posedge clock) begin
		resp_cu_id_q <= resp_cu_id;
		resp_tag_q   <= resp_tag;
	end

////////////////////////////////////////
// steering register
////////////////////////////////////////

	// vertex job id goes to the vertex side and every other id to the algorithm side
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vj_resp_valid  <= 1'b0;
			alg_resp_valid <= 1'b0;
		end else begin
			if (enabled && resp_valid_q) begin
				if (resp_cu_id_q == CU_ID_VERTEX_JOB) begin
					vj_resp_valid  <= 1'b1;
					alg_resp_valid <= 1'b0;
				end else begin
					vj_resp_valid  <= 1'b0;
					alg_resp_valid <= 1'b1;
				end
			end else begin
				vj_resp_valid  <= 1'b0;
				alg_resp_valid <= 1'b0;
			end
		end
	end

	// tag goes to both sides and the valid bits tell which one owns it
	always_ff @(posedge clock) begin
		vj_resp_tag  <= resp_tag_q;
		alg_resp_tag <= resp_tag_q;
	end

endmodule

//--- cu_settings.svh
/*
 * Widths, unit ids and arbiter size for the compute unit control shell.
 * Included by the package and by any module that needs a raw width.
 */

`ifndef CU_SETTINGS_SVH
`define CU_SETTINGS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

`define CU_VERTEX_BITS 32
`define CU_EDGE_BITS 32
`define CU_ADDR_BITS 48
`define CU_TAG_BITS 16
`define CU_CONFIG_BITS 64

////////////////////////////////////////
// unit ids and arbitration
////////////////////////////////////////

`define CU_ID_BITS 4
`define CU_VERTEX_JOB_ID 4'd1
`define CU_ALGORITHM_ID 4'd2
`define CU_NUM_REQUESTERS 2

`endif

//--- files.f
+incdir+.
cu_pkg.sv
cu_response_router.sv
cu_read_arbiter.sv
cu_completion_tracker.sv
cu_control.sv
cu_control_props.sv
cu_control_checker.sv
cu_control_tb.sv
